/* ssram_bus_pkg.sv */
// bus-side definitions for the SSRAM controller.
// holds the Wishbone data and byte-select widths and the request kind.
// modules name these by package scope in their port lists.

package ssram_bus_pkg;

	// data width.
	// the bus and the SSRAM share one 32-bit word.
	localparam int data_w = 32;

	// one select bit per byte lane.
	localparam int sel_w = data_w / 8;

	// request kind latched by the sequencer.
	// taken from we when an access starts.
	typedef enum logic {
		// single-beat read, all lanes enabled.
		op_read  = 1'b0,
		// byte-selectable write.
		op_write = 1'b1
	} bus_op_e;

	// the sequencer holds this for the whole access.
	// the master keeps we steady until ack anyway.

endpackage

/* ssram_dev_pkg.sv */
// device-side definitions for the SSRAM controller.
// gives the default word-address width of the part and the phases
// that the access sequencer steps through for every bus request.

package ssram_dev_pkg;

	// 19 word-address bits.
	// 512k words of 32 bits, bus address bits 20 to 2.
	localparam int addr_w_default = 19;

	// access phases.
	// one phase per clock, only one access in flight.
	typedef enum logic [2:0] {
		// wait for cyc, stb and no ack.
		ph_idle = 3'd0,
		// adsp_n low, address latched by the device.
		ph_addr = 3'd1,
		// byte enables low, we_n low for writes.
		ph_lane = 3'd2,
		// oe_n low, device drives the data bus.
		// reads only.
		ph_read = 3'd3,
		// ack high for one cycle.
		ph_done = 3'd4
	} seq_phase_e;

	// read runs idle, addr, lane, read, done.
	// write skips the read phase.

endpackage

/* ssram_ctrl.sv */
// access sequencer for the SSRAM controller.
// accepts one Wishbone request at a time and walks it through the device
// phases, issuing one-cycle strobes to the command and data paths.
// strobes are decoded from the registered phase so the datapaths
// switch their pins at the very next edge.

`timescale 1ns/10ps

module ssram_ctrl (
	input  logic                    CLK_I,
	input  logic                    RST_I,
	// bus request side.
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	output logic                    ack,
	// latched request kind, shared by both datapaths.
	output ssram_bus_pkg::bus_op_e  op,
	// command path strobes.
	output logic                    addr_load,
	output logic                    lane_set,
	output logic                    lane_clear,
	// data path strobes.
	output logic                    wdata_load,
	output logic                    drive_off,
	output logic                    read_start,
	output logic                    read_end,
	output logic                    capture
);

	import ssram_bus_pkg::*;
	import ssram_dev_pkg::*;

	seq_phase_e phase;
	seq_phase_e phase_nxt;
	logic       req_valid;
	logic       is_read;
	logic       is_write;

	// ack is the done phase itself.
	// no request is seen while it is high.
	assign ack = (phase == ph_done);

	// valid request.
	// cyc and stb high, ack low.
	assign req_valid = cyc & stb & ~ack;

	assign is_read  = (op == op_read);
	assign is_write = (op == op_write);

	// next phase.
	always_comb begin
		phase_nxt = phase;
		case (phase)
			ph_idle: begin
				if (req_valid) begin
					phase_nxt = ph_addr;
				end
			end
			ph_addr: begin
				phase_nxt = ph_lane;
			end
			ph_lane: begin
				// writes finish here while reads still need oe_n.
				phase_nxt = is_write ? ph_done : ph_read;
			end
			ph_read: begin
				phase_nxt = ph_done;
			end
			ph_done: begin
				// held stb restarts from idle one cycle later.
				phase_nxt = ph_idle;
			end
			default: begin
				phase_nxt = ph_idle;
			end
		endcase
	end

	// phase register and latched op.
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			phase <= ph_idle;
			op    <= op_read;
		end else begin
			phase <= phase_nxt;
			// kind is fixed at the start of the access.
			if (phase == ph_idle && req_valid) begin
				op <= we ? op_write : op_read;
			end
		end
	end

	// address and adsp_n at edge 1.
	assign addr_load = (phase == ph_idle) & req_valid;

	// lanes for both kinds at edge 2.
	assign lane_set = (phase == ph_addr);
	// write data goes out with the lanes.
	assign wdata_load = (phase == ph_addr) & is_write;
	// reads release the data bus one cycle before oe_n.
	assign drive_off = (phase == ph_addr) & is_read;

	// oe_n low for reads at edge 3.
	assign read_start = (phase == ph_lane) & is_read;

	// edge 3 for writes and edge 4 for reads.
	assign lane_clear = ((phase == ph_lane) & is_write) | (phase == ph_read);

	// dq_i sampled and the bus handed back at edge 4.
	assign read_end = (phase == ph_read);
	assign capture  = (phase == ph_read);

endmodule

/* ssram_cmd_path.sv */
// command path for the SSRAM controller.
// owns the device address, adsp_n, we_n and the active-low byte enables.
// every pin changes at the edge that samples its strobe from the sequencer.

`timescale 1ns/10ps

module ssram_cmd_path #(
	parameter int ADDR_W = ssram_dev_pkg::addr_w_default
) (
	input  logic                             CLK_I,
	input  logic                             RST_I,
	input  logic [ADDR_W-1:0]                adr,
	input  logic [ssram_bus_pkg::sel_w-1:0]  sel,
	input  ssram_bus_pkg::bus_op_e           op,
	input  logic                             addr_load,
	input  logic                             lane_set,
	input  logic                             lane_clear,
	output logic [ADDR_W-1:0]                dev_adr,
	output logic                             adsp_n,
	output logic                             we_n,
	output logic [ssram_bus_pkg::sel_w-1:0]  be_n
);

	import ssram_bus_pkg::*;

	// word address.
	// master holds adr until ack, one load per access.
	always_ff @(posedge CLK_I) begin
		if (addr_load) begin
			dev_adr <= adr;
		end
	end

	// command pins.
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			adsp_n <= 1'b1;
			we_n   <= 1'b1;
			be_n   <= '1;
		end else begin
			// single-cycle address strobe.
			adsp_n <= ~addr_load;
			if (lane_set) begin
				// reads enable every lane.
				be_n <= (op == op_write) ? ~sel : '0;
				we_n <= (op != op_write);
			end else if (lane_clear) begin
				// end of the lane phase.
				we_n <= 1'b1;
				be_n <= '1;
			end
		end
	end

endmodule

/* ssram_data_path.sv */
// data path for the SSRAM controller.
// holds the write word, the read capture and the bus direction.
// oe_n and dq_oe live together here so the controller and the
// device never drive the data bus in the same cycle.

`timescale 1ns/10ps

module ssram_data_path (
	input  logic                              CLK_I,
	input  logic                              RST_I,
	input  logic [ssram_bus_pkg::data_w-1:0]  dat_w,
	input  logic [ssram_bus_pkg::data_w-1:0]  dq_i,
	input  logic                              wdata_load,
	input  logic                              drive_off,
	input  logic                              read_start,
	input  logic                              read_end,
	input  logic                              capture,
	output logic [ssram_bus_pkg::data_w-1:0]  dq_o,
	output logic                              dq_oe,
	output logic                              oe_n,
	output logic [ssram_bus_pkg::data_w-1:0]  dat_r
);

	// write word.
	// the bus is driven from reset on, so it starts at zero.
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			dq_o <= '0;
		end else if (wdata_load) begin
			dq_o <= dat_w;
		end
	end

	// bus direction and output enable.
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			// controller owns the bus when idle.
			dq_oe <= 1'b1;
			oe_n  <= 1'b1;
		end else begin
			// turnaround cycle ahead of oe_n.
			if (drive_off) begin
				dq_oe <= 1'b0;
			end
			if (read_start) begin
				oe_n  <= 1'b0;
				dq_oe <= 1'b0;
			end
			// device lets go and the controller drives again.
			if (read_end) begin
				oe_n  <= 1'b1;
				dq_oe <= 1'b1;
			end
		end
	end

	// read capture.
	// dat_r holds until the next read.
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			dat_r <= '0;
		end else if (capture) begin
			dat_r <= dq_i;
		end
	end

endmodule

/* ssram_subsystem.sv */
// top level of the SSRAM controller.
// joins a 32-bit Wishbone slave to one pipelined SSRAM.
// reads ack 4 cycles after the request, writes 3 cycles after.
// the data pin is split into dq_o, dq_i and dq_oe; the board or the
// model resolves them into the shared bus.

`timescale 1ns/10ps

module ssram_subsystem #(
	parameter int ADDR_W = ssram_dev_pkg::addr_w_default
) (
	input  logic                              CLK_I,
	input  logic                              RST_I,
	// Wishbone slave.
	input  logic                              cyc,
	input  logic                              stb,
	input  logic                              we,
	input  logic [ADDR_W-1:0]                 adr,
	input  logic [ssram_bus_pkg::sel_w-1:0]   sel,
	input  logic [ssram_bus_pkg::data_w-1:0]  dat_w,
	output logic [ssram_bus_pkg::data_w-1:0]  dat_r,
	output logic                              ack,
	// SSRAM device.
	output logic                              adsp_n,
	output logic                              we_n,
	output logic                              oe_n,
	output logic [ssram_bus_pkg::sel_w-1:0]   be_n,
	output logic [ADDR_W-1:0]                 dev_adr,
	output logic [ssram_bus_pkg::data_w-1:0]  dq_o,
	input  logic [ssram_bus_pkg::data_w-1:0]  dq_i,
	output logic                              dq_oe
);

	import ssram_bus_pkg::*;

	// sequencer to datapaths.
	bus_op_e op;
	logic    addr_load;
	logic    lane_set;
	logic    lane_clear;
	logic    wdata_load;
	logic    drive_off;
	logic    read_start;
	logic    read_end;
	logic    capture;

	// phase sequencer.
	ssram_ctrl ssram_ctrl_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.ack        (ack),
		.op         (op),
		.addr_load  (addr_load),
		.lane_set   (lane_set),
		.lane_clear (lane_clear),
		.wdata_load (wdata_load),
		.drive_off  (drive_off),
		.read_start (read_start),
		.read_end   (read_end),
		.capture    (capture)
	);

	// address and command pins.
	ssram_cmd_path #(
		.ADDR_W (ADDR_W)
	) ssram_cmd_path_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.adr        (adr),
		.sel        (sel),
		.op         (op),
		.addr_load  (addr_load),
		.lane_set   (lane_set),
		.lane_clear (lane_clear),
		.dev_adr    (dev_adr),
		.adsp_n     (adsp_n),
		.we_n       (we_n),
		.be_n       (be_n)
	);

	// data bus, oe_n and read data.
	ssram_data_path ssram_data_path_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.dat_w      (dat_w),
		.dq_i       (dq_i),
		.wdata_load (wdata_load),
		.drive_off  (drive_off),
		.read_start (read_start),
		.read_end   (read_end),
		.capture    (capture),
		.dq_o       (dq_o),
		.dq_oe      (dq_oe),
		.oe_n       (oe_n),
		.dat_r      (dat_r)
	);

endmodule

/* ssram_model.sv */
// behavioral pipelined SSRAM for the testbench.
// latches the word address at an edge with adsp_n low, writes the lanes
// enabled by be_n at an edge with we_n low, and loads its output register
// one edge after the address latch. that word is driven while oe_n is low.
// dq_i is the resolved data bus as the controller sees it.

`timescale 1ns/10ps

module ssram_model #(
	parameter int ADDR_W = ssram_dev_pkg::addr_w_default
) (
	input  logic                              CLK_I,
	input  logic                              RST_I,
	input  logic                              adsp_n,
	input  logic                              we_n,
	input  logic                              oe_n,
	input  logic [ssram_bus_pkg::sel_w-1:0]   be_n,
	input  logic [ADDR_W-1:0]                 dev_adr,
	input  logic [ssram_bus_pkg::data_w-1:0]  dq_o,
	input  logic                              dq_oe,
	output logic [ssram_bus_pkg::data_w-1:0]  dq_i
);

	import ssram_bus_pkg::*;

	logic [data_w-1:0] mem [0:(1 << ADDR_W)-1];
	logic [ADDR_W-1:0] adr_q;
	logic              addr_seen;
	logic [data_w-1:0] rd_q;
	logic [data_w-1:0] bus;
	logic [data_w-1:0] merged;

	// fill word depends on every address bit.
	initial begin
		for (int i = 0; i < (1 << ADDR_W); i++) begin
			mem[ADDR_W'(i)] = 32'hdead_0000 ^ 32'(i);
		end
	end

	// controller side of the bus is zero while released.
	assign bus = dq_oe ? dq_o : '0;

	// byte-lane merge for the write edge.
	always_comb begin
		merged = mem[adr_q];
		for (int b = 0; b < sel_w; b++) begin
			if (!be_n[b]) begin
				merged[8*b +: 8] = bus[8*b +: 8];
			end
		end
	end

	always @(posedge CLK_I) begin
		if (RST_I) begin
			addr_seen <= 1'b0;
		end else begin
			addr_seen <= ~adsp_n;
			if (!adsp_n) begin
				adr_q <= dev_adr;
			end
			// pipeline stage after the address latch.
			if (addr_seen) begin
				rd_q <= mem[adr_q];
			end
			if (!we_n) begin
				mem[adr_q] <= merged;
			end
		end
	end

	// device drives only with oe_n low.
	assign dq_i = oe_n ? bus : rd_q;

endmodule

/* ssram_checker.sv */
// protocol assertions for the SSRAM controller top level.
// bound into ssram_subsystem; fail_cnt counts failed assertions so the
// testbench can fold them into its result.

`timescale 1ns/10ps

module ssram_checker (
	input logic CLK_I,
	input logic RST_I,
	input logic ack,
	input logic adsp_n,
	input logic we_n,
	input logic oe_n,
	input logic dq_oe
);

	int fail_cnt = 0;

	// single-cycle ack.
	ack_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) ack |=> !ack)
		else begin
			fail_cnt++;
			$error("ack stayed high for more than one cycle");
		end

	// one address strobe per access.
	adsp_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) !adsp_n |=> adsp_n)
		else begin
			fail_cnt++;
			$error("adsp_n stayed low for more than one cycle");
		end

	// write and read enables never overlap.
	we_oe_apart: assert property (@(posedge CLK_I) disable iff (RST_I) !(!we_n && !oe_n))
		else begin
			fail_cnt++;
			$error("we_n and oe_n low together");
		end

	// controller off the bus while the device drives.
	no_contention: assert property (@(posedge CLK_I) disable iff (RST_I) !oe_n |-> !dq_oe)
		else begin
			fail_cnt++;
			$error("dq_oe high while oe_n is low");
		end

endmodule

bind ssram_subsystem ssram_checker ssram_checker_inst (
	.CLK_I  (CLK_I),
	.RST_I  (RST_I),
	.ack    (ack),
	.adsp_n (adsp_n),
	.we_n   (we_n),
	.oe_n   (oe_n),
	.dq_oe  (dq_oe)
);

/* tb_ssram_subsystem.sv */
// testbench for the SSRAM controller.
// builds a table of Wishbone accesses whose expected read data comes from
// a shadow memory, applies it to the DUT and the SSRAM model, and checks
// read data and ack latency row by row.

`timescale 1ns/10ps

module tb_ssram_subsystem;

	import ssram_bus_pkg::*;
	import ssram_dev_pkg::*;

	localparam int addr_w       = addr_w_default;
	localparam int reset_cycles = 16;

	// one access; hold keeps stb high into the next row.
	typedef struct packed {
		logic              w;
		logic [31:0]       adr;
		logic [sel_w-1:0]  sel;
		logic [data_w-1:0] dat;
		logic [data_w-1:0] exp;
		logic              hold;
	} row_t;

	logic              CLK_I = 1'b0;
	logic              RST_I;
	logic              cyc;
	logic              stb;
	logic              we;
	logic [addr_w-1:0] adr;
	logic [sel_w-1:0]  sel;
	logic [data_w-1:0] dat_w;
	logic [data_w-1:0] dat_r;
	logic              ack;
	logic              adsp_n;
	logic              we_n;
	logic              oe_n;
	logic [sel_w-1:0]  be_n;
	logic [addr_w-1:0] dev_adr;
	logic [data_w-1:0] dq_o;
	logic [data_w-1:0] dq_i;
	logic              dq_oe;

	row_t              rows[$];
	logic [data_w-1:0] shadow [logic [addr_w-1:0]];
	int                err_cnt = 0;
	int                test_cnt = 0;
	int                bad_tests = 0;
	int                cycle_cnt = 0;
	int                timeout_cycles = 100000;
	int                assert_fails;

	always #5 CLK_I = ~CLK_I;

	ssram_subsystem #(.ADDR_W(addr_w)) ssram_subsystem_inst (.*);
	ssram_model #(.ADDR_W(addr_w)) ssram_model_inst (.*);

	// run limit counted from time zero.
	always @(posedge CLK_I) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: the DUT did not finish within %0d cycles", timeout_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// selected bytes taken from the new word.
	function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old,
			input logic [data_w-1:0] nw, input logic [sel_w-1:0] s);
		logic [data_w-1:0] res;
		res = old;
		for (int b = 0; b < sel_w; b++) begin
			if (s[b]) begin
				res[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic add_row(input logic w, input logic [31:0] a, input logic [sel_w-1:0] s,
			input logic [data_w-1:0] d, input logic h);
		row_t              r;
		logic [addr_w-1:0] wa;
		wa = a[addr_w-1:0];
		if (!shadow.exists(wa)) begin
			shadow[wa] = '0;
		end
		if (w) begin
			shadow[wa] = merge_lanes(shadow[wa], d, s);
		end
		r.w = w;
		r.adr = a;
		r.sel = s;
		r.dat = d;
		r.exp = shadow[wa];
		r.hold = h;
		rows.push_back(r);
	endtask

	task automatic build_table();
		integer      seed;
		logic [31:0] r_adr;
		logic [31:0] r_sel;
		seed = 32'hb2c6_c2c3;
		// full-word round trip.
		add_row(1'b1, 32'h00010, 4'hf, 32'h1234_5678, 1'b0);
		add_row(1'b0, 32'h00010, 4'hf, '0, 1'b0);
		// partial writes over a known word.
		add_row(1'b1, 32'h00020, 4'hf, 32'haabb_ccdd, 1'b0);
		add_row(1'b1, 32'h00020, 4'b0001, 32'h1111_1111, 1'b0);
		add_row(1'b1, 32'h00020, 4'b1010, 32'h2222_2222, 1'b0);
		add_row(1'b0, 32'h00020, 4'hf, '0, 1'b0);
		add_row(1'b1, 32'h00020, 4'b0100, 32'h3333_3333, 1'b0);
		add_row(1'b0, 32'h00020, 4'hf, '0, 1'b0);
		// stb held across a chain at the top word of the space.
		add_row(1'b1, 32'h7ffff, 4'hf, 32'hcafe_f00d, 1'b1);
		add_row(1'b0, 32'h7ffff, 4'hf, '0, 1'b1);
		add_row(1'b1, 32'h7ffff, 4'b0110, 32'h0ff0_0ff0, 1'b1);
		add_row(1'b0, 32'h7ffff, 4'hf, '0, 1'b1);
		add_row(1'b0, 32'h00010, 4'hf, '0, 1'b0);
		// random words get a full write, a random-lane write and a read.
		repeat (6) begin
			r_adr = $random(seed);
			r_sel = $random(seed);
			add_row(1'b1, r_adr, 4'hf, $random(seed), 1'b0);
			add_row(1'b1, r_adr, r_sel[sel_w-1:0], $random(seed), 1'b0);
			add_row(1'b0, r_adr, 4'hf, '0, 1'b0);
		end
	endtask

	// drives one row from a falling edge and waits for ack.
	task automatic run_row(input int i);
		row_t r;
		int   cycles;
		int   exp_lat;
		int   errs_before;
		r = rows[i];
		errs_before = err_cnt;
		cyc = 1'b1;
		stb = 1'b1;
		we = r.w;
		adr = r.adr[addr_w-1:0];
		sel = r.sel;
		dat_w = r.dat;
		// a held stb waits out the ack cycle first.
		exp_lat = r.w ? 3 : 4;
		if (i > 0 && rows[i-1].hold) begin
			exp_lat++;
		end
		cycles = 0;
		do begin
			@(posedge CLK_I);
			@(negedge CLK_I);
			cycles++;
		end while (!ack);
		check_value("ack latency", 32'(cycles), 32'(exp_lat));
		if (!r.w) begin
			check_value("dat_r", dat_r, r.exp);
		end
		if (!r.hold) begin
			cyc = 1'b0;
			stb = 1'b0;
			we = 1'b0;
			@(negedge CLK_I);
			check_value("ack", 32'(ack), 32'h0);
		end
		test_cnt++;
		if (err_cnt != errs_before) begin
			bad_tests++;
		end
		$display("row %0d %s adr %h sel %h: %0d cycles, %s", i, r.w ? "write" : "read",
			r.adr[addr_w-1:0], r.sel, cycles, (err_cnt == errs_before) ? "pass" : "fail");
	endtask

	initial begin
		RST_I = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		dat_w = '0;
		build_table();
		timeout_cycles = rows.size() * 8 + reset_cycles;
		repeat (reset_cycles) @(posedge CLK_I);
		@(negedge CLK_I);
		RST_I = 1'b0;
		@(negedge CLK_I);
		// idle state after reset.
		check_value("ack", 32'(ack), 32'h0);
		check_value("dat_r", dat_r, 32'h0);
		check_value("adsp_n", 32'(adsp_n), 32'h1);
		check_value("we_n", 32'(we_n), 32'h1);
		check_value("oe_n", 32'(oe_n), 32'h1);
		check_value("be_n", 32'(be_n), 32'hf);
		// controller owns the data bus when idle.
		check_value("dq_oe", 32'(dq_oe), 32'h1);
		test_cnt++;
		bad_tests += (err_cnt != 0) ? 1 : 0;
		$display("reset state: %s", (err_cnt == 0) ? "pass" : "fail");
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		assert_fails = ssram_subsystem_inst.ssram_checker_inst.fail_cnt;
		$display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
			test_cnt, bad_tests, err_cnt, assert_fails);
		if (err_cnt == 0 && assert_fails == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* ssram_subsystem.f */
ssram_bus_pkg.sv
ssram_dev_pkg.sv
ssram_ctrl.sv
ssram_cmd_path.sv
ssram_data_path.sv
ssram_subsystem.sv
ssram_model.sv
ssram_checker.sv
tb_ssram_subsystem.sv

/* Makefile */
SRCS := $(shell cat ssram_subsystem.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_ssram_subsystem: ssram_subsystem.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_ssram_subsystem -f ssram_subsystem.f

run: obj_dir/Vtb_ssram_subsystem
	@out="$$(./obj_dir/Vtb_ssram_subsystem +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
